// File: common/c16_pkg.sv
package c16_pkg;

	//////////////////////////////////////////////////
	// Address map constants
	//////////////////////////////////////////////////

	// I/O pages, upper 12 bits of the address
	// ROM banking register block FDD0-FDDF
	localparam logic [11:0] IO_ROMBANK_PAGE = 12'hFDD;
	// Keyboard port latch FD30-FD3F
	localparam logic [11:0] IO_KEYPORT_PAGE = 12'hFD3;
	// Cassette sense FD10-FD1F
	localparam logic [11:0] IO_CASS_PAGE    = 12'hFD1;

	// Keyboard/joystick select register inside the video chip
	localparam logic [15:0] TED_KBD_ADDR = 16'hFF08;

	// High byte of the kernal page, always mapped to bank 0 high half
	localparam logic [7:0]  KERNAL_PAGE  = 8'hFC;

	// External reset hold time after the reset input drops, in clocks
	localparam int unsigned RESET_LEN    = 256;

	// Value of an undriven, pulled-up data bus
	localparam logic [7:0]  IDLE_DATA    = 8'hFF;

	//////////////////////////////////////////////////
	// Address word and its two decodes
	//////////////////////////////////////////////////

	// ROM view: which 16K half plus offset inside the ROM chip
	typedef struct packed {
		logic [1:0]  bank_half;
		logic [13:0] offset;
	} rom_view_t;

	// I/O view: page plus register number inside the page
	typedef struct packed {
		logic [11:0] page;
		logic [3:0]  reg_num;
	} io_view_t;

	typedef union packed {
		logic [15:0] word;
		rom_view_t   rom;
		io_view_t    io;
	} c16_addr_u;

	//////////////////////////////////////////////////
	// Bus cycle and decoded selects
	//////////////////////////////////////////////////

	// One CPU bus cycle, rw high means read
	typedef struct packed {
		c16_addr_u  addr;
		logic [7:0] data;
		logic       rw;
	} bus_cycle_t;

	// One-hot-ish selects decoded from a captured cycle
	typedef struct packed {
		logic rom_bank_wr;
		logic kernal_page;
		logic keyport;
		logic ted_kbd;
		logic cass;
		logic rom_space;
	} chip_sel_t;

endpackage

// File: hw/bus_capture.sv
module bus_capture import c16_pkg::*; (
	input  logic       CLK28,
	input  logic       sreset,
	input  logic       cyc_strobe,
	input  bus_cycle_t cyc,
	output bus_cycle_t cur,
	output chip_sel_t  sel,
	output logic       cur_valid
);

	// Decode of the incoming cycle, registered together with it
	chip_sel_t dec;
	logic      io_region;

	//////////////////////////////////////////////////
	// Address decode
	//////////////////////////////////////////////////

	always_comb begin
		// FDxx and FFxx hold the I/O registers, not ROM
		io_region = (cyc.addr.io.page[11:4] == 8'hFD) ||
			(cyc.addr.io.page[11:4] == 8'hFF);

		dec = '0;
		// Bank register only reacts to writes, data is don't care
		dec.rom_bank_wr = !cyc.rw && (cyc.addr.io.page == IO_ROMBANK_PAGE);
		// Kernal page seen through the ROM view of the address
		dec.kernal_page = ({cyc.addr.rom.bank_half, cyc.addr.rom.offset[13:8]}
			== KERNAL_PAGE);
		dec.keyport     = (cyc.addr.io.page == IO_KEYPORT_PAGE);
		dec.ted_kbd     = (cyc.addr.word == TED_KBD_ADDR);
		dec.cass        = (cyc.addr.io.page == IO_CASS_PAGE);
		// Upper 32K is ROM except for the I/O holes
		dec.rom_space   = cyc.addr.rom.bank_half[1] && !io_region;
	end

	//////////////////////////////////////////////////
	// Cycle latch
	//////////////////////////////////////////////////

	// Valid flag and selects
	always_ff @(posedge CLK28) begin
		if (sreset) begin
			cur_valid <= 1'b0;
			sel       <= '0;
		end else begin
			cur_valid <= cyc_strobe;
			if (cyc_strobe)
				sel <= dec;
		end
	end

	// Address and data payload, held until the next strobe
	always_ff @(posedge CLK28) begin
		if (cyc_strobe)
			cur <= cyc;
	end

endmodule

// File: hw/rom_bank.sv
module rom_bank import c16_pkg::*; (
	input  logic       CLK28,
	input  logic       sreset,
	input  bus_cycle_t cur,
	input  chip_sel_t  sel,
	input  logic       cur_valid,
	output logic [3:0] rom_sel
);

	// Bank register
	// 3:2 select the high ROM, 1:0 select the low ROM
	logic [3:0] bank_q;
	// Current cycle fetches from the kernal page
	logic       kern;

	// Low nibble of the address picks the banks, data bus unused
	always_ff @(posedge CLK28) begin
		if (sreset)
			bank_q <= 4'h0;
		else if (cur_valid && sel.rom_bank_wr)
			bank_q <= cur.addr.io.reg_num;
	end

	// FCxx is always kernal
	assign kern = cur_valid && sel.rom_space && sel.kernal_page;

	// Force high bank to 0 for kernal fetches, low half passes through
	assign rom_sel = {bank_q[3:2] & {2{~kern}}, bank_q[1:0]};

endmodule

// File: hw/keyport.sv
module keyport import c16_pkg::*; (
	input  logic       CLK28,
	input  logic       sreset,
	input  bus_cycle_t cur,
	input  chip_sel_t  sel,
	input  logic       cur_valid,
	input  logic [7:0] kbd_cols,
	input  logic [4:0] joy0,
	input  logic [4:0] joy1,
	output logic [7:0] kbd_row,
	output logic [7:0] kbus,
	output logic [7:0] port_rd
);

	// Row latch, the 6529 style port
	logic [7:0] row_q;
	// Joystick selects from FF08, active low
	logic       joy0_sel_n;
	logic       joy1_sel_n;
	// Write qualifiers
	logic       port_wr;
	logic       kbd_wr;
	// Per-joystick masks in key bus polarity, 4 = fire
	logic [4:0] joy0_mask;
	logic [4:0] joy1_mask;

	assign port_wr = cur_valid && !cur.rw && sel.keyport;
	assign kbd_wr  = cur_valid && !cur.rw && sel.ted_kbd;

	//////////////////////////////////////////////////
	// Latches
	//////////////////////////////////////////////////

	// Idle row drive is all ones, no row pulled low
	always_ff @(posedge CLK28) begin
		if (sreset)
			row_q <= 8'hFF;
		else if (port_wr)
			row_q <= cur.data;
	end

	// Data bit 2 picks joystick 0, bit 1 joystick 1
	always_ff @(posedge CLK28) begin
		if (sreset) begin
			joy0_sel_n <= 1'b1;
			joy1_sel_n <= 1'b1;
		end else if (kbd_wr) begin
			joy0_sel_n <= cur.data[2];
			joy1_sel_n <= cur.data[1];
		end
	end

	// Port is output only, reads return the last write
	assign kbd_row = row_q;
	assign port_rd = row_q;

	//////////////////////////////////////////////////
	// Key column merge
	//////////////////////////////////////////////////

	// Pressed line pulls its column low when the stick is selected
	assign joy0_mask = joy0_sel_n ? 5'h1F : ~joy0;
	assign joy1_mask = joy1_sel_n ? 5'h1F : ~joy1;

	// Directions share bits 3..0
	assign kbus[3:0] = kbd_cols[3:0] & joy0_mask[3:0] & joy1_mask[3:0];
	// No joystick line here
	assign kbus[5:4] = kbd_cols[5:4];
	// Fire buttons get a column each
	assign kbus[6]   = kbd_cols[6] & joy0_mask[4];
	assign kbus[7]   = kbd_cols[7] & joy1_mask[4];

endmodule

// File: hw/reset_stretch.sv
module reset_stretch import c16_pkg::*; (
	input  logic CLK28,
	input  logic sreset,
	output logic ext_reset
);

	// Counts clocks since the reset input dropped
	logic [$clog2(RESET_LEN)-1:0] cnt;

	// Restart on every reset input clock
	// then hold ext_reset until the full length has passed
	always_ff @(posedge CLK28) begin
		if (sreset) begin
			cnt       <= '0;
			ext_reset <= 1'b1;
		end else if (ext_reset) begin
			cnt <= cnt + 1'b1;
			// Last held cycle, release on this edge
			if (cnt == $bits(cnt)'(RESET_LEN - 1))
				ext_reset <= 1'b0;
		end
	end

endmodule

// File: hw/read_mux.sv
module read_mux import c16_pkg::*; (
	input  logic       CLK28,
	input  logic       sreset,
	input  bus_cycle_t cur,
	input  chip_sel_t  sel,
	input  logic       cur_valid,
	input  logic [7:0] port_rd,
	input  logic [7:0] kbus,
	input  logic       cass_sense,
	output logic       rd_strobe,
	output logic [7:0] rd_data
);

	// Each source floats high when not addressed
	logic [7:0] port_word;
	logic [7:0] kbd_word;
	logic [7:0] cass_word;
	logic [7:0] bus_word;

	assign port_word = sel.keyport ? port_rd : IDLE_DATA;
	assign kbd_word  = sel.ted_kbd ? kbus : IDLE_DATA;
	// Only bit 2 is driven, rest pulled up
	assign cass_word = {5'b11111, sel.cass ? cass_sense : 1'b1, 2'b11};

	// Wired-AND data bus, unmapped and ROM space stay FF
	assign bus_word = port_word & kbd_word & cass_word;

	// Strobe for reads only
	always_ff @(posedge CLK28) begin
		if (sreset)
			rd_strobe <= 1'b0;
		else
			rd_strobe <= cur_valid && cur.rw;
	end

	always_ff @(posedge CLK28) begin
		if (cur_valid && cur.rw)
			rd_data <= bus_word;
	end

endmodule

// File: hw/c16_glue_top.sv
module c16_glue_top import c16_pkg::*; (
	input  logic       CLK28,
	input  logic       sreset,

	// Bus master side
	input  logic       cyc_strobe,
	input  bus_cycle_t cyc,
	output logic       rd_strobe,
	output logic [7:0] rd_data,

	// Board inputs
	input  logic       cass_sense,
	input  logic [7:0] kbd_cols,
	input  logic [4:0] joy0,
	input  logic [4:0] joy1,

	// Board outputs
	output logic [3:0] rom_sel,
	output logic [7:0] kbd_row,
	output logic [7:0] kbus,
	output logic       ext_reset
);

	// Captured cycle, shared by all consumers
	bus_cycle_t cur;
	chip_sel_t  sel;
	logic       cur_valid;
	// Keyport latch readback
	logic [7:0] port_rd;

	//////////////////////////////////////////////////
	// Input side
	//////////////////////////////////////////////////

	bus_capture capture_i (
		.CLK28      (CLK28),
		.sreset     (sreset),
		.cyc_strobe (cyc_strobe),
		.cyc        (cyc),
		.cur        (cur),
		.sel        (sel),
		.cur_valid  (cur_valid)
	);

	//////////////////////////////////////////////////
	// Registers
	//////////////////////////////////////////////////

	rom_bank bank_i (
		.CLK28     (CLK28),
		.sreset    (sreset),
		.cur       (cur),
		.sel       (sel),
		.cur_valid (cur_valid),
		.rom_sel   (rom_sel)
	);

	keyport keyport_i (
		.CLK28     (CLK28),
		.sreset    (sreset),
		.cur       (cur),
		.sel       (sel),
		.cur_valid (cur_valid),
		.kbd_cols  (kbd_cols),
		.joy0      (joy0),
		.joy1      (joy1),
		.kbd_row   (kbd_row),
		.kbus      (kbus),
		.port_rd   (port_rd)
	);

	// Emulates the long power-on reset of the real board
	reset_stretch reset_i (
		.CLK28     (CLK28),
		.sreset    (sreset),
		.ext_reset (ext_reset)
	);

	//////////////////////////////////////////////////
	// Output side
	//////////////////////////////////////////////////

	read_mux rdmux_i (
		.CLK28      (CLK28),
		.sreset     (sreset),
		.cur        (cur),
		.sel        (sel),
		.cur_valid  (cur_valid),
		.port_rd    (port_rd),
		.kbus       (kbus),
		.cass_sense (cass_sense),
		.rd_strobe  (rd_strobe),
		.rd_data    (rd_data)
	);

endmodule

// File: testbench/c16_glue_props.sv
module c16_glue_props import c16_pkg::*; (
	input logic       CLK28,
	input logic       sreset,
	input logic       cyc_strobe,
	input bus_cycle_t cyc,
	input logic       rd_strobe,
	input logic       ext_reset
);

	// Read data comes back two clocks after the read is strobed
	rd_after_read: assert property (@(posedge CLK28) disable iff (sreset)
		cyc_strobe && cyc.rw |-> ##2 rd_strobe)
		else $error("rd_strobe missing two clocks after a read");

	// Writes return nothing
	no_rd_after_write: assert property (@(posedge CLK28) disable iff (sreset)
		cyc_strobe && !cyc.rw |-> ##2 !rd_strobe)
		else $error("rd_strobe after a write");

	// Reset output follows the reset input
	ext_reset_in_reset: assert property (@(posedge CLK28) sreset |=> ext_reset)
		else $error("ext_reset low during sreset");

endmodule

bind c16_glue_top c16_glue_props props_i (
	.CLK28      (CLK28),
	.sreset     (sreset),
	.cyc_strobe (cyc_strobe),
	.cyc        (cyc),
	.rd_strobe  (rd_strobe),
	.ext_reset  (ext_reset)
);

// File: testbench/tb_c16_glue.sv
module tb_c16_glue import c16_pkg::*; ();

	logic       CLK28;
	logic       sreset;
	logic       cyc_strobe;
	bus_cycle_t cyc;
	logic       cass_sense;
	logic [7:0] kbd_cols;
	logic [4:0] joy0;
	logic [4:0] joy1;
	logic       rd_strobe;
	logic [7:0] rd_data;
	logic [3:0] rom_sel;
	logic [7:0] kbd_row;
	logic [7:0] kbus;
	logic       ext_reset;

	// One outstanding read with its data and the falling edge it is due at
	typedef struct packed {
		logic [7:0]  data;
		logic [31:0] due;
	} exp_rd_t;

	exp_rd_t     exp_q[$];
	integer      seed = 32'hd28a_2cf2;
	// Reference state
	logic [3:0]  m_bank;
	logic [7:0]  m_row;
	logic        m_joy0_on;
	logic        m_joy1_on;
	// Cycle the DUT holds as current after the next rising edge
	logic        p_stb;
	bus_cycle_t  p_cyc;
	logic [31:0] now;
	int          errors;
	int          test_errs;
	int          tests_run;
	int          tests_failed;
	bit          timed_out;
	string       test_name;

	c16_glue_top dut_i (.*);

	initial begin
		CLK28 = 1'b0;
		forever #50 CLK28 = ~CLK28;
	end

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	// Pressed and selected stick lines pull their key columns low
	function automatic logic [7:0] model_kbus(input logic [7:0] cols, input logic [4:0] j0,
		input logic [4:0] j1);
		logic [4:0] p0;
		logic [4:0] p1;
		p0 = m_joy0_on ? j0 : 5'h00;
		p1 = m_joy1_on ? j1 : 5'h00;
		return {cols[7] & ~p1[4], cols[6] & ~p0[4], cols[5:4], cols[3:0] & ~p0[3:0] & ~p1[3:0]};
	endfunction

	// Each addressed source drives its bits on the pulled-up bus
	function automatic logic [7:0] model_read(input logic [15:0] a);
		logic [7:0] d;
		d = IDLE_DATA;
		if (a[15:4] == IO_KEYPORT_PAGE)
			d = d & m_row;
		if (a == TED_KBD_ADDR)
			d = d & model_kbus(kbd_cols, joy0, joy1);
		if (a[15:4] == IO_CASS_PAGE)
			d[2] = cass_sense;
		return d;
	endfunction

	task automatic model_write(input bus_cycle_t c);
		// Bank nibble comes from the address and the data is ignored
		if (c.addr.word[15:4] == IO_ROMBANK_PAGE)
			m_bank = c.addr.word[3:0];
		if (c.addr.word[15:4] == IO_KEYPORT_PAGE)
			m_row = c.data;
		if (c.addr.word == TED_KBD_ADDR) begin
			m_joy0_on = !c.data[2];
			m_joy1_on = !c.data[1];
		end
	endtask

	task automatic mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
		errors++;
		test_errs++;
		$display("ERR %s %s: expected %0h, actual %0h", test_name, what, exp, act);
	endtask

	task automatic fault(input string what);
		errors++;
		test_errs++;
		$display("%s: %s", test_name, what);
	endtask

	//////////////////////////////////////////////////
	// One clock of stimulus and checking
	//////////////////////////////////////////////////

	task automatic tick(input logic stb, input logic [15:0] addr, input logic rw,
		input logic [7:0] data);
		logic [31:0] r;
		logic        kern;
		logic [3:0]  exp_sel;
		exp_rd_t     e;
		@(negedge CLK28);
		now++;
		// Read returns come back oldest first
		if (rd_strobe === 1'b1) begin
			if (exp_q.size() == 0) begin
				fault("rd_strobe came with no read pending");
			end else begin
				e = exp_q.pop_front();
				if (now != e.due)
					mismatch("read latency", e.due, now);
				if (rd_data !== e.data)
					mismatch("rd_data", 32'(e.data), 32'(rd_data));
			end
		end else if (exp_q.size() != 0 && exp_q[0].due <= now) begin
			fault("read data never came back");
			e = exp_q.pop_front();
		end
		// Kernal fetch in flight hides the high bank bits
		kern = p_stb && (p_cyc.addr.word[15:8] == KERNAL_PAGE);
		exp_sel = m_bank;
		if (kern)
			exp_sel[3:2] = 2'b00;
		if (rom_sel !== exp_sel)
			mismatch("rom_sel", 32'(exp_sel), 32'(rom_sel));
		if (kbd_row !== m_row)
			mismatch("kbd_row", 32'(m_row), 32'(kbd_row));
		if (kbus !== model_kbus(kbd_cols, joy0, joy1))
			mismatch("kbus", 32'(model_kbus(kbd_cols, joy0, joy1)), 32'(kbus));
		// New board inputs with the columns mostly released
		r = $random(seed);
		kbd_cols = r[7:0] | r[30:23];
		joy0 = r[12:8];
		joy1 = r[17:13];
		cass_sense = r[18];
		// Current cycle reads with the inputs it sees now and writes land after
		if (p_stb && p_cyc.rw) begin
			e.data = model_read(p_cyc.addr.word);
			e.due = now + 1;
			exp_q.push_back(e);
		end else if (p_stb) begin
			model_write(p_cyc);
		end
		// Junk on the bus when not strobed
		r = $random(seed);
		cyc_strobe = stb;
		cyc.addr.word = stb ? addr : r[15:0];
		cyc.data = stb ? data : r[23:16];
		cyc.rw = stb ? rw : r[24];
		p_stb = stb;
		p_cyc = cyc;
	endtask

	// Address kinds 0 bank regs, 1 kernal page, 2 keyport, 3 FF08, 4 cassette, 5 anywhere
	task automatic rand_cycle(input int kind_lo, input int kind_hi, input bit gaps);
		logic [31:0] r;
		logic [15:0] a;
		int          kind;
		kind = kind_lo + ($unsigned($random(seed)) % (kind_hi - kind_lo + 1));
		r = $random(seed);
		case (kind)
			0: a = {IO_ROMBANK_PAGE, r[3:0]};
			1: a = {KERNAL_PAGE, r[7:0]};
			2: a = {IO_KEYPORT_PAGE, r[3:0]};
			3: a = TED_KBD_ADDR;
			4: a = {IO_CASS_PAGE, r[3:0]};
			default: a = r[15:0];
		endcase
		tick(!gaps || r[17:16] != 2'b00, a, r[18], r[27:20]);
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errs = 0;
	endtask

	// Drain outstanding reads then report
	task automatic end_test();
		int n;
		n = 0;
		while ((p_stb || exp_q.size() != 0) && n < 8) begin
			tick(1'b0, 16'h0000, 1'b1, 8'h00);
			n++;
		end
		if (p_stb || exp_q.size() != 0) begin
			fault("timed out waiting for read data");
			timed_out = 1'b1;
		end
		tests_run++;
		if (test_errs != 0)
			tests_failed++;
		$display("test %s finished, %0d errors", test_name, test_errs);
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		int          n;
		logic [31:0] r;
		sreset = 1'b1;
		cyc_strobe = 1'b0;
		cyc = '0;
		cass_sense = 1'b0;
		kbd_cols = 8'hFF;
		joy0 = 5'h00;
		joy1 = 5'h00;
		m_bank = 4'h0;
		m_row = 8'hFF;
		m_joy0_on = 1'b0;
		m_joy1_on = 1'b0;
		p_stb = 1'b0;
		p_cyc = '0;
		now = 0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		timed_out = 1'b0;

		// Reset held 8 clocks before counting the stretch
		start_test("reset_release");
		repeat (8) begin
			tick(1'b0, 16'h0000, 1'b1, 8'h00);
			if (ext_reset !== 1'b1)
				fault("ext_reset is low while sreset is high");
		end
		sreset = 1'b0;
		n = 0;
		while (ext_reset === 1'b1 && n < RESET_LEN + 16) begin
			tick(1'b0, 16'h0000, 1'b1, 8'h00);
			n++;
		end
		if (ext_reset === 1'b1) begin
			fault("timed out waiting for ext_reset to fall");
			timed_out = 1'b1;
		end else if (n != RESET_LEN) begin
			mismatch("ext_reset length", RESET_LEN, 32'(n));
		end
		if (rd_strobe !== 1'b0)
			mismatch("rd_strobe", 32'h0, 32'(rd_strobe));
		end_test();

		if (!timed_out) begin
			start_test("rom_bank");
			repeat (300) rand_cycle(0, 1, 1'b1);
			end_test();
		end
		// Write then read on the very next strobe
		if (!timed_out) begin
			start_test("keyport");
			repeat (100) begin
				r = $random(seed);
				tick(1'b1, {IO_KEYPORT_PAGE, r[3:0]}, 1'b0, r[15:8]);
				tick(1'b1, {IO_KEYPORT_PAGE, r[7:4]}, 1'b1, 8'h00);
			end
			repeat (100) rand_cycle(2, 2, 1'b1);
			end_test();
		end
		if (!timed_out) begin
			start_test("joystick_merge");
			repeat (400) rand_cycle(3, 3, 1'b1);
			end_test();
		end
		if (!timed_out) begin
			start_test("cass_and_unmapped");
			repeat (400) rand_cycle(4, 5, 1'b1);
			end_test();
		end
		if (!timed_out) begin
			start_test("back_to_back");
			repeat (2000) rand_cycle(0, 5, 1'b0);
			end_test();
		end

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0 && !timed_out)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// File: filelist.f
common/c16_pkg.sv
hw/bus_capture.sv
hw/rom_bank.sv
hw/keyport.sv
hw/reset_stretch.sv
hw/read_mux.sv
hw/c16_glue_top.sv
testbench/c16_glue_props.sv
testbench/tb_c16_glue.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_c16_glue -f filelist.f --Mdir obj_dir -o tb_c16_glue
	./obj_dir/tb_c16_glue | tee /dev/stderr | grep -q "TEST PASS"

clean:
	rm -rf obj_dir
